// ==== ppu_bg_line.f ====
logic/ppu_bg_pkg.sv
logic/vram_store.sv
logic/line_sequencer.sv
logic/bg_fetcher.sv
logic/bg_pixel_shifter.sv
logic/ppu_bg_line.sv
test/ppu_bg_line_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the background line testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -Wno-fatal \
  --top-module ppu_bg_line_tb \
  --Mdir obj_dir \
  -o ppu_bg_line_sim \
  -f ppu_bg_line.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/ppu_bg_line_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi

// ==== test/ppu_bg_line_tb.sv ====
`timescale 1ns/100ps

module ppu_bg_line_tb;

  import ppu_bg_pkg::*;

  localparam int SCREEN_WIDTH = 160;
  localparam int RESET_CYCLES = 16;
  localparam int VRAM_BYTES   = 8192;
  localparam int IDLE_CYCLES  = 40;
  // Lines driven over all tests
  localparam int NUM_LINES    = 27;
  localparam int LINE_CYCLES  = SCREEN_WIDTH * 2 + 50;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + VRAM_BYTES + IDLE_CYCLES +
                                   NUM_LINES * (LINE_CYCLES + 8) + 500;

  logic       clk;
  logic       reset;
  logic       vram_we;
  vram_wr_t   vram_wr;
  logic       line_start;
  ppu_regs_t  regs;
  logic       px_valid;
  pixel_out_t px;
  logic       line_done;

  // Copy of what the host wrote into video memory
  logic [7:0] shadow [0:VRAM_BYTES-1];
  int         seed;
  logic       started;
  logic       model_visible;
  int         model_win_line;
  // Pixels seen so far on the current line
  int         pix_count;
  logic       done_seen;
  // {from_window, shade} expected for pixel pix_count
  logic [2:0] exp_pixel;
  int         test_errors;
  int         total_errors;
  int         tests_run;
  int         tests_failed;

  ppu_bg_line #(
    .SCREEN_WIDTH(SCREEN_WIDTH)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .vram_we    (vram_we),
    .vram_wr    (vram_wr),
    .line_start (line_start),
    .regs       (regs),
    .px_valid   (px_valid),
    .px         (px),
    .line_done  (line_done)
  );

  always #2 clk = ~clk;

  // Reference for one background or window pixel
  function automatic logic [2:0] model_pixel(input int x, input ppu_regs_t r,
                                             input logic visible, input int win_line);
    int          win_start;
    int          col;
    int          map_x;
    int          map_y;
    int          data_addr;
    int          bit_pos;
    logic [12:0] map_base;
    logic        win;
    tile_id_u    tid;
    logic [7:0]  lo;
    logic [7:0]  hi;
    logic [1:0]  c;
    win_start = (int'(r.wx) < 7) ? 0 : int'(r.wx) - 7;
    col       = x / 8;
    win       = visible && (col * 8 >= win_start);
    if (win) begin
      map_base = r.lcdc[6] ? MAP_HIGH_BASE : MAP_LOW_BASE;
      // Window map starts at the first whole tile it covers
      map_x    = (col - (win_start + 7) / 8) % 32;
      map_y    = win_line % 256;
    end else begin
      map_base = r.lcdc[3] ? MAP_HIGH_BASE : MAP_LOW_BASE;
      map_x    = (int'(r.scx) / 8 + col) % 32;
      map_y    = (int'(r.scy) + int'(r.ly)) % 256;
    end
    tid = shadow[int'(map_base) + (map_y / 8) * 32 + map_x];
    // Same map byte, two readings
    if (r.lcdc[4]) begin
      data_addr = int'(DATA_UNSIGNED_BASE) + int'(tid.unsigned_idx) * 16;
    end else begin
      data_addr = int'(DATA_SIGNED_BASE) + int'(tid.signed_idx) * 16;
    end
    data_addr = data_addr + (map_y % 8) * 2;
    lo        = shadow[data_addr];
    hi        = shadow[data_addr + 1];
    // Bit 7 is the leftmost pixel of the tile
    bit_pos   = 7 - x % 8;
    c         = {hi[bit_pos], lo[bit_pos]};
    return {win, r.bgp[int'(c) * 2 +: 2]};
  endfunction

  always_comb begin
    exp_pixel = model_pixel(pix_count, regs, model_visible, model_win_line);
  end

  // Per-line pixel and line_done tracking
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      pix_count <= 0;
      done_seen <= 1'b0;
    end else begin
      if (line_start) begin
        pix_count <= 0;
        done_seen <= 1'b0;
      end
      if (px_valid) begin
        pix_count <= pix_count + 1;
      end
      if (line_done) begin
        done_seen <= 1'b1;
      end
    end
  end

  a_idle_quiet : assert property (@(posedge clk) disable iff (reset)
    !started |-> (!px_valid && !line_done)
  ) else begin
    $display("output strobe seen at %0t before any line was started", $time);
    test_errors++;
  end

  a_px_x : assert property (@(posedge clk) disable iff (reset)
    px_valid |-> (px.x == 8'(pix_count))
  ) else begin
    $display("error %0t px.x expected %0d got %0d", $time, $sampled(pix_count),
             $sampled(px.x));
    test_errors++;
  end

  a_px_shade : assert property (@(posedge clk) disable iff (reset)
    px_valid |-> (px.shade == exp_pixel[1:0])
  ) else begin
    $display("error %0t px.shade expected %0d got %0d", $time, $sampled(exp_pixel[1:0]),
             $sampled(px.shade));
    test_errors++;
  end

  a_px_window : assert property (@(posedge clk) disable iff (reset)
    px_valid |-> (px.from_window == exp_pixel[2])
  ) else begin
    $display("error %0t px.from_window expected %0d got %0d", $time,
             $sampled(exp_pixel[2]), $sampled(px.from_window));
    test_errors++;
  end

  a_px_in_line : assert property (@(posedge clk) disable iff (reset)
    px_valid |-> (!done_seen && pix_count < SCREEN_WIDTH)
  ) else begin
    $display("pixel strobe at %0t after the line was already complete", $time);
    test_errors++;
  end

  a_done_count : assert property (@(posedge clk) disable iff (reset)
    line_done |-> (pix_count == SCREEN_WIDTH)
  ) else begin
    $display("error %0t px_valid count expected %0d got %0d", $time, SCREEN_WIDTH,
             $sampled(pix_count));
    test_errors++;
  end

  a_done_once : assert property (@(posedge clk) disable iff (reset)
    line_done |-> !done_seen
  ) else begin
    $display("line_done pulsed more than once in one line at %0t", $time);
    test_errors++;
  end

  // Random bytes over all of video memory, maps included
  task automatic load_vram();
    int         addr;
    logic [7:0] data;
    for (addr = 0; addr < VRAM_BYTES; addr++) begin
      data         = 8'($random(seed));
      shadow[addr] = data;
      @(negedge clk);
      vram_we      = 1'b1;
      vram_wr.addr = 13'(addr);
      vram_wr.data = data;
    end
    @(negedge clk);
    vram_we = 1'b0;
  endtask

  task automatic run_line(input logic [7:0] lcdc, input logic [7:0] scy,
                          input logic [7:0] scx, input logic [7:0] ly,
                          input logic [7:0] wy, input logic [7:0] wx,
                          input logic [7:0] bgp);
    int waited;
    @(negedge clk);
    if (ly == 8'd0) begin
      model_win_line = 0;
    end
    model_visible = lcdc[5] && (ly >= wy) && (int'(wx) - 7 < SCREEN_WIDTH);
    regs          = '{lcdc: lcdc, scy: scy, scx: scx, ly: ly, wy: wy, wx: wx, bgp: bgp};
    started       = 1'b1;
    line_start    = 1'b1;
    @(negedge clk);
    line_start = 1'b0;
    waited     = 0;
    while (!done_seen && waited < LINE_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!done_seen) begin
      $display("line %0d did not finish within %0d cycles", ly, LINE_CYCLES);
      test_errors++;
    end
    // Window line counter moves only after a line that drew the window
    if (model_visible) begin
      model_win_line++;
    end
    // Room for a stray second line_done to show
    repeat (4) @(negedge clk);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int line;
    clk            = 1'b0;
    reset          = 1'b1;
    vram_we        = 1'b0;
    vram_wr        = '0;
    line_start     = 1'b0;
    regs           = '0;
    seed           = 62;
    started        = 1'b0;
    model_visible  = 1'b0;
    model_win_line = 0;
    test_errors    = 0;
    total_errors   = 0;
    tests_run      = 0;
    tests_failed   = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    repeat (IDLE_CYCLES) @(negedge clk);
    finish_test("idle after reset");
    load_vram();

    // Unsigned tile data, low map
    run_line(8'h91, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'hE4);
    run_line(8'h91, 8'd0, 8'd13, 8'd1, 8'd0, 8'd0, 8'hE4);
    run_line(8'h91, 8'd37, 8'd100, 8'd2, 8'd0, 8'd0, 8'hE4);
    run_line(8'h91, 8'd201, 8'd250, 8'd143, 8'd0, 8'd0, 8'hE4);
    finish_test("unsigned tile data");

    // Signed tile data, then the high map
    run_line(8'h81, 8'd5, 8'd64, 8'd10, 8'd0, 8'd0, 8'hE4);
    run_line(8'h89, 8'd120, 8'd3, 8'd50, 8'd0, 8'd0, 8'hE4);
    run_line(8'h89, 8'd255, 8'd255, 8'd100, 8'd0, 8'd0, 8'hE4);
    finish_test("signed tile data");

    // Window from x 40 down from line 2, one hidden line, then a new frame
    for (line = 0; line < 5; line++) begin
      run_line(8'hF1, 8'd0, 8'd0, 8'(line), 8'd2, 8'd47, 8'hE4);
    end
    run_line(8'hF1, 8'd0, 8'd0, 8'd5, 8'd2, 8'd170, 8'hE4);
    run_line(8'hF1, 8'd0, 8'd0, 8'd6, 8'd2, 8'd47, 8'hE4);
    for (line = 0; line < 4; line++) begin
      run_line(8'hF1, 8'd9, 8'd20, 8'(line), 8'd2, 8'd47, 8'hE4);
    end
    // WX below 7 covers the whole line
    run_line(8'hF1, 8'd0, 8'd0, 8'd4, 8'd2, 8'd3, 8'hE4);
    finish_test("window");

    for (line = 7; line < 10; line++) begin
      run_line(8'h91, 8'd0, 8'd7, 8'(line), 8'd0, 8'd0, 8'hE4);
    end
    finish_test("pixel count and line_done");

    run_line(8'h91, 8'd30, 8'd16, 8'd20, 8'd0, 8'd0, 8'hE4);
    run_line(8'h91, 8'd30, 8'd16, 8'd20, 8'd0, 8'd0, 8'h1B);
    run_line(8'h91, 8'd30, 8'd16, 8'd20, 8'd0, 8'd0, 8'h00);
    run_line(8'h91, 8'd30, 8'd16, 8'd20, 8'd0, 8'd0, 8'hFF);
    run_line(8'h91, 8'd30, 8'd16, 8'd20, 8'd0, 8'd0, 8'h9C);
    finish_test("palette change");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
             total_errors);
    if (tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from reset, memory load and all lines
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== logic/ppu_bg_line.sv ====
`timescale 1ns/100ps

module ppu_bg_line #(
  parameter int SCREEN_WIDTH = 160
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   vram_we,
  input  ppu_bg_pkg::vram_wr_t   vram_wr,
  input  logic                   line_start,
  input  ppu_bg_pkg::ppu_regs_t  regs,
  output logic                   px_valid,
  output ppu_bg_pkg::pixel_out_t px,
  output logic                   line_done
);

  import ppu_bg_pkg::*;

  line_ctx_t   ctx;
  logic        rd_en;
  logic [12:0] rd_addr;
  logic [7:0]  rd_data;
  logic        row_empty;
  logic        row_load;
  pixel_row_t  row;
  logic        row_from_window;

  line_sequencer #(
    .SCREEN_WIDTH(SCREEN_WIDTH)
  ) sequencer_i (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .regs       (regs),
    .line_done  (line_done),
    .ctx        (ctx)
  );

  vram_store vram_i (
    .clk     (clk),
    .reset   (reset),
    .we      (vram_we),
    .wr      (vram_wr),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  bg_fetcher #(
    .SCREEN_WIDTH(SCREEN_WIDTH)
  ) fetcher_i (
    .clk             (clk),
    .reset           (reset),
    .regs            (regs),
    .ctx             (ctx),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .row_empty       (row_empty),
    .row_load        (row_load),
    .row             (row),
    .row_from_window (row_from_window)
  );

  bg_pixel_shifter #(
    .SCREEN_WIDTH(SCREEN_WIDTH)
  ) shifter_i (
    .clk             (clk),
    .reset           (reset),
    .regs            (regs),
    .row_load        (row_load),
    .row             (row),
    .row_from_window (row_from_window),
    .row_empty       (row_empty),
    .px_valid        (px_valid),
    .px              (px),
    .line_done       (line_done)
  );

endmodule

// ==== logic/bg_pixel_shifter.sv ====
`timescale 1ns/100ps

module bg_pixel_shifter #(
  parameter int SCREEN_WIDTH = 160
) (
  input  logic                   clk,
  input  logic                   reset,
  input  ppu_bg_pkg::ppu_regs_t  regs,
  input  logic                   row_load,
  input  ppu_bg_pkg::pixel_row_t row,
  input  logic                   row_from_window,
  output logic                   row_empty,
  output logic                   px_valid,
  output ppu_bg_pkg::pixel_out_t px,
  output logic                   line_done
);

  import ppu_bg_pkg::*;

  // Count of pixels still held in shift_q
  logic [3:0]  count;
  pixel_row_t  shift_q;
  logic        win_q;
  // Next x to emit
  logic [7:0]  x;
  logic        last_px;

  // Color c picks bgp[2c+1:2c]
  function automatic logic [1:0] map_shade(input logic [7:0] bgp, input color_id_t c);
    map_shade = bgp[{c, 1'b0} +: 2];
  endfunction

  assign row_empty = (count == 4'd0);
  assign last_px   = (x == 8'(SCREEN_WIDTH - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count     <= 4'd0;
      x         <= 8'd0;
      px_valid  <= 1'b0;
      line_done <= 1'b0;
    end else begin
      px_valid  <= 1'b0;
      // One cycle after the last pixel of the line
      line_done <= px_valid && (px.x == 8'(SCREEN_WIDTH - 1));
      if (row_load) begin
        count <= 4'd8;
      end else if (!row_empty) begin
        px_valid <= 1'b1;
        if (last_px) begin
          // Line is full so the rest of the row is dropped
          count <= 4'd0;
          x     <= 8'd0;
        end else begin
          count <= count - 4'd1;
          x     <= x + 8'd1;
        end
      end
    end
  end

  // Row data and output pixel
  always_ff @(posedge clk) begin
    if (row_load) begin
      shift_q <= row;
      win_q   <= row_from_window;
    end else if (!row_empty) begin
      // Leftmost pixel leaves from the top
      shift_q        <= shift_q << 2;
      px.x           <= x;
      px.shade       <= map_shade(regs.bgp, shift_q[7]);
      px.from_window <= win_q;
    end
  end

endmodule

// ==== logic/bg_fetcher.sv ====
`timescale 1ns/100ps

module bg_fetcher #(
  parameter int SCREEN_WIDTH = 160
) (
  input  logic                   clk,
  input  logic                   reset,
  input  ppu_bg_pkg::ppu_regs_t  regs,
  input  ppu_bg_pkg::line_ctx_t  ctx,
  output logic                   rd_en,
  output logic [12:0]            rd_addr,
  input  logic [7:0]             rd_data,
  input  logic                   row_empty,
  output logic                   row_load,
  output ppu_bg_pkg::pixel_row_t row,
  output logic                   row_from_window
);

  import ppu_bg_pkg::*;

  // Rows needed to cover one line
  localparam int NUM_TILES = (SCREEN_WIDTH + 7) / 8;

  typedef enum logic [2:0] {
    GET_TILE,
    GET_LOW,
    GET_HIGH,
    PUSH,
    LINE_END
  } fetch_state_t;

  fetch_state_t state;
  fetch_state_t next_read_state;
  // 0 = address out, 1 = data latched
  logic         phase;
  // Tile column on screen, counts pushes
  logic [5:0]   col;

  tile_id_u     tile_id;
  logic [7:0]   low_byte;
  logic [7:0]   high_byte;

  logic signed [9:0] win_x_signed;
  logic [7:0]        win_x_start;
  logic [8:0]        win_start_sum;
  logic [5:0]        win_start_tile;
  logic              window_active;
  logic [12:0]       map_base;
  logic [4:0]        map_x;
  logic [7:0]        map_y;
  logic [12:0]       map_addr;
  logic [12:0]       data_addr;
  logic [12:0]       read_addr;
  logic              push;

  // Tile row address from the map byte
  // Signed mode reaches 0x0800-0x17FF around DATA_SIGNED_BASE
  function automatic logic [12:0] tile_row_addr(input logic     unsigned_mode,
                                                input tile_id_u id,
                                                input logic [2:0] line);
    logic [12:0] base;
    logic [12:0] index_offset;
    if (unsigned_mode) begin
      base         = DATA_UNSIGNED_BASE;
      index_offset = {1'b0, id.unsigned_idx, 4'b0000};
    end else begin
      base         = DATA_SIGNED_BASE;
      // Sign extend index x16 to 13 bits
      index_offset = {id.signed_idx[7], id.signed_idx, 4'b0000};
    end
    tile_row_addr = base + index_offset + {9'd0, line, 1'b0};
  endfunction

  always_comb begin
    // max(0, WX - 7)
    win_x_signed = $signed({2'b00, regs.wx}) - 10'sd7;
    win_x_start  = (win_x_signed < 0) ? 8'd0 : win_x_signed[7:0];
    // First tile column drawn by the window, rounded up
    win_start_sum  = {1'b0, win_x_start} + 9'd7;
    win_start_tile = win_start_sum[8:3];

    window_active = ctx.window_visible && ({col, 3'b000} >= {1'b0, win_x_start});

    if (window_active) begin
      map_base = regs.lcdc[LCDC_WIN_MAP] ? MAP_HIGH_BASE : MAP_LOW_BASE;
      map_x    = 5'(col - win_start_tile);
      map_y    = ctx.window_line;
    end else begin
      map_base = regs.lcdc[LCDC_BG_MAP] ? MAP_HIGH_BASE : MAP_LOW_BASE;
      // Wraps at 32 columns and 256 lines
      map_x    = regs.scx[7:3] + col[4:0];
      map_y    = regs.scy + regs.ly;
    end

    // 32 map bytes per tile row
    map_addr  = map_base + {3'b000, map_y[7:3], map_x};
    data_addr = tile_row_addr(regs.lcdc[LCDC_TILE_DATA], tile_id, map_y[2:0]);

    // Address and follow-on state for the three read states
    case (state)
      GET_TILE: begin
        read_addr       = map_addr;
        next_read_state = GET_LOW;
      end
      GET_LOW: begin
        read_addr       = data_addr;
        next_read_state = GET_HIGH;
      end
      default: begin
        // High byte sits right after the low byte
        read_addr       = data_addr + 13'd1;
        next_read_state = PUSH;
      end
    endcase

    push = ctx.active && (state == PUSH) && row_empty;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= GET_TILE;
      phase    <= 1'b0;
      col      <= 6'd0;
      rd_en    <= 1'b0;
      rd_addr  <= 13'd0;
      row_load <= 1'b0;
    end else if (!ctx.active) begin
      // Idle between lines, next line starts at column 0
      state    <= GET_TILE;
      phase    <= 1'b0;
      col      <= 6'd0;
      rd_en    <= 1'b0;
      row_load <= 1'b0;
    end else begin
      row_load <= 1'b0;
      unique case (state)
        GET_TILE, GET_LOW, GET_HIGH: begin
          phase <= !phase;
          rd_en <= !phase;
          if (!phase) begin
            rd_addr <= read_addr;
          end else begin
            state <= next_read_state;
          end
        end
        PUSH: begin
          // Wait here until the shifter has drained
          if (row_empty) begin
            row_load <= 1'b1;
            col      <= col + 6'd1;
            state    <= (col == 6'(NUM_TILES - 1)) ? LINE_END : GET_TILE;
          end
        end
        LINE_END: begin
          // Line fully fetched, hold until active drops
          state <= LINE_END;
        end
      endcase
    end
  end

  // Fetched bytes and the outgoing row
  always_ff @(posedge clk) begin
    if (ctx.active && phase) begin
      if (state == GET_TILE) begin
        tile_id.unsigned_idx <= rd_data;
      end else if (state == GET_LOW) begin
        low_byte <= rd_data;
      end else if (state == GET_HIGH) begin
        high_byte <= rd_data;
      end
    end
    if (push) begin
      // Bit 7 of each byte is the leftmost pixel
      for (int i = 0; i < 8; i++) begin
        row[i] <= {high_byte[i], low_byte[i]};
      end
      row_from_window <= window_active;
    end
  end

  // Shifter never gets a row on top of pixels it still holds
  a_load_when_empty : assert property (
    @(posedge clk) disable iff (reset)
    row_load |-> row_empty
  );

endmodule

// ==== logic/line_sequencer.sv ====
`timescale 1ns/100ps

module line_sequencer #(
  parameter int SCREEN_WIDTH = 160
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  line_start,
  input  ppu_bg_pkg::ppu_regs_t regs,
  input  logic                  line_done,
  output ppu_bg_pkg::line_ctx_t ctx
);

  import ppu_bg_pkg::*;

  // WX - 7 can go negative, keep a sign bit and room for 255
  logic signed [9:0] win_x_signed;
  logic              visible_now;

  always_comb begin
    win_x_signed = $signed({2'b00, regs.wx}) - 10'sd7;
    // Window shows on this line once LY reaches WY and it starts on screen
    visible_now = regs.lcdc[LCDC_WIN_EN] &&
                  (regs.ly >= regs.wy) &&
                  (win_x_signed < $signed(10'(SCREEN_WIDTH)));
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctx <= '0;
    end else if (line_start) begin
      ctx.active         <= 1'b1;
      ctx.window_visible <= visible_now;
      // First line of the frame restarts the window line counter
      if (regs.ly == 8'd0) begin
        ctx.window_line <= 8'd0;
      end
    end else if (line_done) begin
      ctx.active <= 1'b0;
      // Counter only moves on lines that actually drew the window
      if (ctx.window_visible) begin
        ctx.window_line <= ctx.window_line + 8'd1;
      end
    end
  end

  // Host must wait for line_done before the next line
  a_start_while_idle : assert property (
    @(posedge clk) disable iff (reset)
    line_start |-> !ctx.active
  );

endmodule

// ==== logic/vram_store.sv ====
`timescale 1ns/100ps

module vram_store (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 we,
  input  ppu_bg_pkg::vram_wr_t wr,
  input  logic                 rd_en,
  input  logic [12:0]          rd_addr,
  output logic [7:0]           rd_data
);

  localparam int DEPTH = 1 << 13;

  // Tile data 0x0000-0x17FF, maps 0x1800-0x1FFF
  logic [7:0] mem [0:DEPTH-1];

  // Host port, one byte per strobe
  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Fetcher port
  // Address is already registered in the fetcher, so read straight through
  assign rd_data = mem[rd_addr];

  // Host only loads memory between lines, never under a fetcher read
  a_no_write_during_read : assert property (
    @(posedge clk) disable iff (reset)
    (rd_en && !$stable(rd_addr)) |-> !we
  );

endmodule

// ==== logic/ppu_bg_pkg.sv ====
package ppu_bg_pkg;

  // Offsets into the 8 KiB video memory, which starts at 0x8000
  localparam logic [12:0] MAP_LOW_BASE       = 13'h1800;
  localparam logic [12:0] MAP_HIGH_BASE      = 13'h1C00;
  localparam logic [12:0] DATA_UNSIGNED_BASE = 13'h0000;
  localparam logic [12:0] DATA_SIGNED_BASE   = 13'h1000;

  // LCDC bit positions used by the background path
  localparam int LCDC_BG_MAP    = 3;
  localparam int LCDC_TILE_DATA = 4;
  localparam int LCDC_WIN_EN    = 5;
  localparam int LCDC_WIN_MAP   = 6;

  // Register set, held stable by the host for a whole line
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] ly;
    logic [7:0] wy;
    logic [7:0] wx;
    logic [7:0] bgp;
  } ppu_regs_t;

  // Per-line state handed from sequencer to fetcher
  typedef struct packed {
    logic       active;
    logic       window_visible;
    logic [7:0] window_line;
  } line_ctx_t;

  // Raw 2-bit color before BGP
  typedef logic [1:0] color_id_t;

  // Element 7 is the leftmost pixel, same order as the tile bytes
  typedef color_id_t [7:0] pixel_row_t;

  // Map byte, read as unsigned (LCDC.4 set) or signed (LCDC.4 clear)
  typedef union packed {
    logic [7:0]        unsigned_idx;
    logic signed [7:0] signed_idx;
  } tile_id_u;

  // One output pixel
  typedef struct packed {
    logic [7:0] x;
    logic [1:0] shade;
    logic       from_window;
  } pixel_out_t;

  // Host write into video memory
  typedef struct packed {
    logic [12:0] addr;
    logic [7:0]  data;
  } vram_wr_t;

endpackage
